/* hw/rv_pkg.sv */
package rv_pkg;

    // datapath widths
    localparam int word_width = 32;
    localparam int reg_addr_width = 5;
    localparam int address_width_default = 16;

    // sequencer steps, one per cycle while running
    typedef enum logic [2:0] {
        st_init,
        st_fetch,
        st_fetch2,
        st_decode,
        st_registers,
        st_alu,
        st_step,
        st_halted
    } seq_state_t;

    // major opcode groups of RV32I
    typedef enum logic [3:0] {
        op_alu_imm,
        op_alu_reg,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_system,
        op_other
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

/* hw/decode_if.sv */
`timescale 1ns/1ps

interface decode_if;
    import rv_pkg::*;

    op_class_t op_class;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [2:0] funct3;
    logic funct7_bit5;
    logic [word_width-1:0] imm_i;
    logic [word_width-1:0] imm_u;

    modport producer (
        output op_class, rd, rs1, rs2, funct3, funct7_bit5, imm_i, imm_u
    );

    // register read addresses are taken straight off the bus at the top
    modport consumer (
        input op_class, rd, funct3, funct7_bit5, imm_i, imm_u
    );

endinterface

/* hw/block_ram.sv */
`timescale 1ns/1ps

module block_ram #(
    parameter int word_width = rv_pkg::word_width,
    parameter int address_width = rv_pkg::address_width_default
) (
    input  logic                     clock,
    input  logic                     write,
    input  logic [address_width-1:0] write_address,
    input  logic [word_width-1:0]    write_data,
    input  logic [address_width-1:0] read_address,
    output logic [word_width-1:0]    read_data
);

    logic [word_width-1:0] mem [2**address_width];

    // one write port, read data registered
    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_address] <= write_data;
        end
        read_data <= mem[read_address];
    end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              write,
    input  logic [rv_pkg::reg_addr_width-1:0] write_address,
    input  logic [rv_pkg::word_width-1:0]     write_data,
    input  logic [rv_pkg::reg_addr_width-1:0] read1_address,
    output logic [rv_pkg::word_width-1:0]     read1_data,
    input  logic [rv_pkg::reg_addr_width-1:0] read2_address,
    output logic [rv_pkg::word_width-1:0]     read2_data
);
    import rv_pkg::*;

    logic [word_width-1:0] regs [2**reg_addr_width];

    // architectural registers start from zero
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write && write_address != '0) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 is hardwired
    assign read1_data = (read1_address == '0) ? '0 : regs[read1_address];
    assign read2_data = (read2_address == '0) ? '0 : regs[read2_address];

endmodule

/* hw/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input logic [rv_pkg::word_width-1:0] inst,
    decode_if.producer                   dec
);
    import rv_pkg::*;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opc_alu_imm = 7'b0010011;
    localparam logic [6:0] opc_alu_reg = 7'b0110011;
    localparam logic [6:0] opc_lui     = 7'b0110111;
    localparam logic [6:0] opc_auipc   = 7'b0010111;
    localparam logic [6:0] opc_jal     = 7'b1101111;
    localparam logic [6:0] opc_jalr    = 7'b1100111;
    localparam logic [6:0] opc_branch  = 7'b1100011;
    localparam logic [6:0] opc_load    = 7'b0000011;
    localparam logic [6:0] opc_store   = 7'b0100011;
    localparam logic [6:0] opc_system  = 7'b1110011;

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            opc_alu_imm: dec.op_class = op_alu_imm;
            opc_alu_reg: dec.op_class = op_alu_reg;
            opc_lui:     dec.op_class = op_lui;
            opc_auipc:   dec.op_class = op_auipc;
            opc_jal:     dec.op_class = op_jal;
            opc_jalr:    dec.op_class = op_jalr;
            opc_branch:  dec.op_class = op_branch;
            opc_load:    dec.op_class = op_load;
            opc_store:   dec.op_class = op_store;
            opc_system:  dec.op_class = op_system;
            default:     dec.op_class = op_other;
        endcase
    end

    // register and function fields sit at fixed positions
    assign dec.rd = inst[11:7];
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.funct3 = inst[14:12];
    assign dec.funct7_bit5 = inst[30];

    // sign-extended 12 bit immediate
    assign dec.imm_i = {{20{inst[31]}}, inst[31:20]};

    // upper 20 bits, low bits zero
    assign dec.imm_u = {inst[31:12], 12'b0};

endmodule

/* hw/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
    input  rv_pkg::alu_op_t              op,
    input  logic [rv_pkg::word_width-1:0] operand_a,
    input  logic [rv_pkg::word_width-1:0] operand_b,
    output logic [rv_pkg::word_width-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic lt_signed;
    logic lt_unsigned;

    assign shamt = operand_b[4:0];
    assign lt_signed = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (op)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_sll:  result = operand_a << shamt;
            alu_slt:  result = {{(word_width-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(word_width-1){1'b0}}, lt_unsigned};
            alu_xor:  result = operand_a ^ operand_b;
            alu_srl:  result = operand_a >> shamt;
            // arithmetic shift keeps the sign bit
            alu_sra:  result = $unsigned($signed(operand_a) >>> shamt);
            alu_or:   result = operand_a | operand_b;
            alu_and:  result = operand_a & operand_b;
            default:  result = '0;
        endcase
    end

endmodule

/* hw/core_sequencer.sv */
`timescale 1ns/1ps

module core_sequencer #(
    parameter int address_width = rv_pkg::address_width_default
) (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              run,
    input  logic [address_width-1:0]          ext_write_address,
    input  logic [rv_pkg::word_width-1:0]     ext_write_data,
    input  logic                              ext_enable_write_inst,
    input  logic                              ext_decode_inst,
    input  logic [rv_pkg::word_width-1:0]     ext_inst_to_decode,
    input  logic [rv_pkg::word_width-1:0]     ram_read_data,
    input  logic [rv_pkg::word_width-1:0]     rs1_value,
    input  logic [rv_pkg::word_width-1:0]     rs2_value,
    input  logic [rv_pkg::word_width-1:0]     alu_result,
    decode_if.consumer                        dec,
    output logic [rv_pkg::word_width-1:0]     inst_to_decode,
    output logic [address_width-1:0]          ram_address,
    output logic                              ram_write,
    output logic [rv_pkg::word_width-1:0]     ram_write_data,
    output rv_pkg::alu_op_t                   alu_op,
    output logic [rv_pkg::word_width-1:0]     alu_a,
    output logic [rv_pkg::word_width-1:0]     alu_b,
    output logic                              rd_write,
    output logic [rv_pkg::reg_addr_width-1:0] rd_address,
    output logic [rv_pkg::word_width-1:0]     rd_data,
    output logic                              halted
);
    import rv_pkg::*;

    seq_state_t state;
    logic [address_width-1:0] pc;
    logic is_alu_class;
    logic writes_rd;
    logic is_ebreak;

    assign is_alu_class = (dec.op_class == op_alu_imm) || (dec.op_class == op_alu_reg);
    assign writes_rd = (is_alu_class || dec.op_class == op_lui) && (dec.rd != '0);
    assign is_ebreak = (dec.op_class == op_system) && (dec.imm_i[11:0] == 12'd1);

    // lui goes through the adder as imm_u + 0
    assign alu_a = (dec.op_class == op_lui) ? dec.imm_u : rs1_value;
    assign alu_b = (dec.op_class == op_alu_reg) ? rs2_value :
                   (dec.op_class == op_lui) ? '0 : dec.imm_i;

    always_comb begin
        alu_op = alu_add;
        if (is_alu_class) begin
            case (dec.funct3)
                3'b000: begin
                    // no subi, so bit 30 only matters for the register form
                    if (dec.op_class == op_alu_reg && dec.funct7_bit5) begin
                        alu_op = alu_sub;
                    end
                end
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = dec.funct7_bit5 ? alu_sra : alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= st_init;
            pc <= '0;
            ram_write <= 1'b0;
            rd_write <= 1'b0;
            halted <= 1'b0;
        end else begin
            // both strobes are single-cycle pulses
            rd_write <= 1'b0;
            ram_write <= 1'b0;
            if (!run) begin
                // stopped, so the load port owns the RAM and the decoder
                if (ext_decode_inst) begin
                    inst_to_decode <= ext_inst_to_decode;
                end
                if (ext_enable_write_inst) begin
                    ram_address <= ext_write_address;
                    ram_write_data <= ext_write_data;
                    ram_write <= 1'b1;
                end
            end else begin
                case (state)
                    st_init: begin
                        pc <= '0;
                        state <= st_fetch;
                    end
                    st_fetch: begin
                        ram_address <= pc;
                        state <= st_fetch2;
                    end
                    // RAM read latency
                    st_fetch2: state <= st_decode;
                    st_decode: begin
                        inst_to_decode <= ram_read_data;
                        state <= st_registers;
                    end
                    st_registers: begin
                        if (is_ebreak) begin
                            halted <= 1'b1;
                        end
                        state <= st_alu;
                    end
                    st_alu: begin
                        rd_data <= alu_result;
                        rd_address <= dec.rd;
                        rd_write <= writes_rd;
                        state <= halted ? st_halted : st_step;
                    end
                    st_step: begin
                        pc <= pc + address_width'(4);
                        state <= st_fetch;
                    end
                    // only reset leaves here
                    st_halted: state <= st_halted;
                    default: state <= st_init;
                endcase
            end
        end
    end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter int address_width = rv_pkg::address_width_default
) (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic                              run,
    input  logic [address_width-1:0]          ext_write_address,
    input  logic [rv_pkg::word_width-1:0]     ext_write_data,
    input  logic                              ext_enable_write_inst,
    input  logic                              ext_decode_inst,
    input  logic [rv_pkg::word_width-1:0]     ext_inst_to_decode,
    output logic                              halted,
    output rv_pkg::op_class_t                 decode_class,
    output logic [rv_pkg::reg_addr_width-1:0] decode_rd,
    output logic [rv_pkg::reg_addr_width-1:0] decode_rs1,
    output logic [rv_pkg::reg_addr_width-1:0] decode_rs2,
    output logic [rv_pkg::word_width-1:0]     decode_imm_i,
    output logic [rv_pkg::word_width-1:0]     decode_imm_u,
    output logic                              reg_write,
    output logic [rv_pkg::reg_addr_width-1:0] reg_write_address,
    output logic [rv_pkg::word_width-1:0]     reg_write_data
);
    import rv_pkg::*;

    decode_if dec_bus ();

    logic [word_width-1:0] inst_to_decode;
    logic [address_width-1:0] ram_address;
    logic ram_write;
    logic [word_width-1:0] ram_write_data;
    logic [word_width-1:0] ram_read_data;
    logic [word_width-1:0] rs1_value;
    logic [word_width-1:0] rs2_value;
    alu_op_t alu_op;
    logic [word_width-1:0] alu_a;
    logic [word_width-1:0] alu_b;
    logic [word_width-1:0] alu_result;

    // word-addressed RAM, byte offset dropped
    block_ram #(
        .word_width(word_width),
        .address_width(address_width - 2)
    ) inst_ram (
        .clock(clock),
        .write(ram_write),
        .write_address(ram_address[address_width-1:2]),
        .write_data(ram_write_data),
        .read_address(ram_address[address_width-1:2]),
        .read_data(ram_read_data)
    );

    register_file registers (
        .clock(clock),
        .reset_n(reset_n),
        .write(reg_write),
        .write_address(reg_write_address),
        .write_data(reg_write_data),
        .read1_address(dec_bus.rs1),
        .read1_data(rs1_value),
        .read2_address(dec_bus.rs2),
        .read2_data(rs2_value)
    );

    inst_decoder decoder (
        .inst(inst_to_decode),
        .dec(dec_bus)
    );

    int_alu alu (
        .op(alu_op),
        .operand_a(alu_a),
        .operand_b(alu_b),
        .result(alu_result)
    );

    core_sequencer #(
        .address_width(address_width)
    ) sequencer (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .ext_write_address(ext_write_address),
        .ext_write_data(ext_write_data),
        .ext_enable_write_inst(ext_enable_write_inst),
        .ext_decode_inst(ext_decode_inst),
        .ext_inst_to_decode(ext_inst_to_decode),
        .ram_read_data(ram_read_data),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .alu_result(alu_result),
        .dec(dec_bus),
        .inst_to_decode(inst_to_decode),
        .ram_address(ram_address),
        .ram_write(ram_write),
        .ram_write_data(ram_write_data),
        .alu_op(alu_op),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .rd_write(reg_write),
        .rd_address(reg_write_address),
        .rd_data(reg_write_data),
        .halted(halted)
    );

    // decode fields brought out for inspection
    assign decode_class = dec_bus.op_class;
    assign decode_rd = dec_bus.rd;
    assign decode_rs1 = dec_bus.rs1;
    assign decode_rs2 = dec_bus.rs2;
    assign decode_imm_i = dec_bus.imm_i;
    assign decode_imm_u = dec_bus.imm_u;

endmodule

/* tests/rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva (
    input logic                              clock,
    input logic                              reset_n,
    input logic                              run,
    input logic                              halted,
    input logic                              reg_write,
    input logic [rv_pkg::reg_addr_width-1:0] reg_write_address
);

    // halt is sticky until a reset edge
    halt_sticky: assert property (@(posedge clock) $fell(halted) |-> !$past(reset_n))
        else $error("halted fell without a reset");

    // a write pulse only comes out of a running, unhalted core
    write_when_running: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(reg_write) |-> $past(run) && !$past(halted))
        else $error("reg_write rose while stopped or halted");

    write_after_halt: assert property (@(posedge clock) disable iff (!reset_n)
        reg_write |-> !halted)
        else $error("reg_write high while halted");

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clock) disable iff (!reset_n)
        reg_write |-> reg_write_address != '0)
        else $error("reg_write to x0");

endmodule

bind rv_core rv_core_sva sva_i (
    .clock(clock),
    .reset_n(reset_n),
    .run(run),
    .halted(halted),
    .reg_write(reg_write),
    .reg_write_address(reg_write_address)
);

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int n_decode = 24;
    localparam int n_seed = 15;
    localparam int n_imm = 40;
    localparam int n_reg = 40;
    localparam int n_lui = 6;
    localparam int n_other = 8;
    localparam int n_halt = 10;

    // program lengths include the closing ebreak
    localparam int imm_len = 2 * n_seed + n_imm + 1;
    localparam int reg_len = 2 * n_seed + n_reg + 1;
    localparam int lui_len = 5 * n_lui + 1;
    localparam int other_len = 2 * n_seed + 4 * n_other + 1;
    localparam int halt_len = 2 * n_seed + 2 * n_halt + 2;
    localparam int total_inst = imm_len + reg_len + lui_len + other_len + halt_len;
    // load plus six run cycles per instruction, resets, decode checks and margin
    localparam int watchdog_cycles = total_inst * 7 + 6 * 60 + n_decode * 2 + 1000;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [6:0] opc_imm = 7'b0010011;

    logic clock;
    logic reset_n;
    logic run;
    logic [15:0] ext_write_address;
    logic [31:0] ext_write_data;
    logic ext_enable_write_inst;
    logic ext_decode_inst;
    logic [31:0] ext_inst_to_decode;
    logic halted;
    op_class_t decode_class;
    logic [4:0] decode_rd;
    logic [4:0] decode_rs1;
    logic [4:0] decode_rs2;
    logic [31:0] decode_imm_i;
    logic [31:0] decode_imm_u;
    logic reg_write;
    logic [4:0] reg_write_address;
    logic [31:0] reg_write_data;

    logic [31:0] model_regs [32];
    logic [31:0] program_q[$];
    logic [4:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int writes_seen = 0;

    rv_core #(
        .address_width(16)
    ) dut_i (
        .clock(clock),
        .reset_n(reset_n),
        .run(run),
        .ext_write_address(ext_write_address),
        .ext_write_data(ext_write_data),
        .ext_enable_write_inst(ext_enable_write_inst),
        .ext_decode_inst(ext_decode_inst),
        .ext_inst_to_decode(ext_inst_to_decode),
        .halted(halted),
        .decode_class(decode_class),
        .decode_rd(decode_rd),
        .decode_rs1(decode_rs1),
        .decode_rs2(decode_rs2),
        .decode_imm_i(decode_imm_i),
        .decode_imm_u(decode_imm_u),
        .reg_write(reg_write),
        .reg_write_address(reg_write_address),
        .reg_write_data(reg_write_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * 4);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // writes are compared in program order against the model
    always @(negedge clock) begin
        if (reset_n && reg_write) begin
            writes_seen++;
            assert (exp_addr_q.size() > 0) else begin
                $display("unexpected register write to x%0d at %0t", reg_write_address, $time);
                errors++;
            end
            if (exp_addr_q.size() > 0) begin
                check_value("reg_write_address", 32'(reg_write_address),
                            32'(exp_addr_q.pop_front()));
                check_value("reg_write_data", reg_write_data, exp_data_q.pop_front());
            end
        end
    end

    // RV32I ALU semantics selected by funct3 and the sub/sra bit
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        logic [31:0] fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            // signed compare by flipping the sign bits
            3'd2: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? ((a >> sh) | fill) : (a >> sh);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic op_class_t class_of(input logic [6:0] opcode);
        case (opcode)
            7'b0010011: return op_alu_imm;
            7'b0110011: return op_alu_reg;
            7'b0110111: return op_lui;
            7'b0010111: return op_auipc;
            7'b1101111: return op_jal;
            7'b1100111: return op_jalr;
            7'b1100011: return op_branch;
            7'b0000011: return op_load;
            7'b0100011: return op_store;
            7'b1110011: return op_system;
            default: return op_other;
        endcase
    endfunction

    function automatic logic [6:0] pick_opcode(input int unsigned sel);
        case (sel)
            0: return 7'b0010011;
            1: return 7'b0110011;
            2: return 7'b0110111;
            3: return 7'b0010111;
            4: return 7'b1101111;
            5: return 7'b1100111;
            6: return 7'b1100011;
            7: return 7'b0000011;
            8: return 7'b0100011;
            9: return 7'b1110011;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // append one instruction and advance the model
    task automatic emit(input logic [31:0] word, input logic [4:0] rd, input logic [31:0] value);
        program_q.push_back(word);
        if (rd != 5'd0) begin
            model_regs[rd] = value;
            exp_addr_q.push_back(rd);
            exp_data_q.push_back(value);
        end
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        run = 1'b0;
        ext_enable_write_inst = 1'b0;
        ext_decode_inst = 1'b0;
        repeat (16) step();
        reset_n = 1'b1;
        model_regs = '{default: '0};
        program_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        @(negedge clock);
        assert (!halted && !reg_write) else begin
            $display("halted or reg_write still high after reset at %0t", $time);
            errors++;
        end
        step();
    endtask

    task automatic load_program();
        for (int i = 0; i < program_q.size(); i++) begin
            ext_write_address = 16'(i * 4);
            ext_write_data = program_q[i];
            ext_enable_write_inst = 1'b1;
            step();
        end
        ext_enable_write_inst = 1'b0;
        step();
        step();
    endtask

    task automatic execute_program(input string name);
        int waited;
        int limit;
        program_q.push_back(ebreak_word);
        load_program();
        limit = program_q.size() * 6 + 20;
        waited = 0;
        run = 1'b1;
        while (!halted && waited < limit) begin
            step();
            waited++;
        end
        assert (halted) else begin
            $display("halted never rose while running %s", name);
            errors++;
        end
        // idle a little so that a stray write would show up
        repeat (8) step();
        assert (exp_addr_q.size() == 0) else begin
            $display("%0d expected register writes missing in %s", exp_addr_q.size(), name);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    task automatic seed_pair(input logic [4:0] rd);
        logic [19:0] upper;
        logic [11:0] lower;
        upper = 20'($urandom);
        lower = 12'($urandom);
        emit(u_type(upper, rd), rd, {upper, 12'd0});
        emit(i_type(lower, rd, 3'd0, rd), rd, {upper, 12'd0} + {{20{lower[11]}}, lower});
    endtask

    task automatic add_imm_op();
        logic [2:0] f3;
        logic [4:0] rs1;
        logic [4:0] rd;
        logic [11:0] imm;
        logic alt;
        f3 = 3'($urandom);
        rs1 = 5'($urandom % 16);
        rd = 5'($urandom);
        imm = 12'($urandom);
        alt = 1'b0;
        if (f3 == 3'd1) begin
            imm = {7'd0, imm[4:0]};
        end else if (f3 == 3'd5) begin
            alt = imm[10];
            imm = {1'b0, alt, 5'd0, imm[4:0]};
        end
        emit(i_type(imm, rs1, f3, rd), rd,
             alu_model(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic add_reg_op(input int op_sel);
        logic [2:0] f3;
        logic alt;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        alt = (op_sel == 1) || (op_sel == 7);
        case (op_sel)
            0, 1: f3 = 3'd0;
            2: f3 = 3'd1;
            3: f3 = 3'd2;
            4: f3 = 3'd3;
            5: f3 = 3'd4;
            6, 7: f3 = 3'd5;
            8: f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        rs1 = 5'($urandom % 16);
        rs2 = 5'($urandom % 16);
        rd = 5'($urandom);
        emit(r_type(alt ? 7'b0100000 : 7'd0, rs2, rs1, f3, rd), rd,
             alu_model(f3, alt, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic seed_all();
        for (int r = 1; r <= n_seed; r++) begin
            seed_pair(5'(r));
        end
    endtask

    task automatic check_decode_fields();
        int start;
        logic [31:0] word;
        start = errors;
        for (int i = 0; i < n_decode; i++) begin
            word = {25'($urandom), pick_opcode($urandom % 11)};
            ext_inst_to_decode = word;
            ext_decode_inst = 1'b1;
            step();
            ext_decode_inst = 1'b0;
            @(negedge clock);
            check_value("decode_class", 32'(decode_class), 32'(class_of(word[6:0])));
            check_value("decode_rd", 32'(decode_rd), 32'(word[11:7]));
            check_value("decode_rs1", 32'(decode_rs1), 32'(word[19:15]));
            check_value("decode_rs2", 32'(decode_rs2), 32'(word[24:20]));
            check_value("decode_imm_i", decode_imm_i, 32'($signed(word[31:20])));
            check_value("decode_imm_u", decode_imm_u, word & 32'hffff_f000);
            step();
        end
        report_test("decode", start);
    endtask

    task automatic imm_ops_program();
        int start;
        start = errors;
        apply_reset();
        seed_all();
        for (int i = 0; i < n_imm; i++) begin
            add_imm_op();
        end
        execute_program("imm_ops");
        report_test("imm_ops", start);
    endtask

    task automatic reg_ops_program();
        int start;
        start = errors;
        apply_reset();
        seed_all();
        for (int i = 0; i < n_reg; i++) begin
            add_reg_op(i % 10);
        end
        execute_program("reg_ops");
        report_test("reg_ops", start);
    endtask

    task automatic lui_and_x0_program();
        int start;
        logic [4:0] rd;
        logic [4:0] rd2;
        logic [19:0] upper;
        logic [11:0] imm;
        start = errors;
        apply_reset();
        for (int i = 0; i < n_lui; i++) begin
            rd = 5'(1 + $urandom % 31);
            rd2 = 5'(1 + $urandom % 31);
            upper = 20'($urandom);
            imm = 12'($urandom);
            emit(u_type(upper, rd), rd, {upper, 12'd0});
            // x0 destinations write nothing
            emit(u_type(20'($urandom), 5'd0), 5'd0, 32'd0);
            emit(i_type(imm, rd, 3'd0, 5'd0), 5'd0, 32'd0);
            emit(r_type(7'd0, 5'd0, 5'd0, 3'd0, rd2), rd2, 32'd0);
            emit(i_type(imm, 5'd0, 3'd6, rd2), rd2, {{20{imm[11]}}, imm});
        end
        execute_program("lui_x0");
        report_test("lui_x0", start);
    endtask

    task automatic non_alu_program();
        int start;
        start = errors;
        apply_reset();
        seed_all();
        for (int i = 0; i < n_other; i++) begin
            add_imm_op();
            emit({25'($urandom), 7'b1100011}, 5'd0, 32'd0);
            emit({25'($urandom), 7'b0100011}, 5'd0, 32'd0);
            emit({25'($urandom), 7'b1101111}, 5'd0, 32'd0);
        end
        execute_program("non_alu");
        report_test("non_alu", start);
    endtask

    task automatic ebreak_program();
        int start;
        start = errors;
        apply_reset();
        seed_all();
        for (int i = 0; i < n_halt; i++) begin
            add_imm_op();
        end
        program_q.push_back(ebreak_word);
        // never reached, so the model sees none of these
        for (int i = 0; i < n_halt; i++) begin
            program_q.push_back(i_type(12'($urandom), 5'd0, 3'd0, 5'(1 + i)));
        end
        execute_program("ebreak");
        check_value("halted", 32'(halted), 32'd1);
        run = 1'b0;
        apply_reset();
        check_value("halted", 32'(halted), 32'd0);
        report_test("ebreak", start);
    endtask

    initial begin
        void'($urandom(32'h153f_4218));
        reset_n = 1'b0;
        run = 1'b0;
        ext_write_address = '0;
        ext_write_data = '0;
        ext_enable_write_inst = 1'b0;
        ext_decode_inst = 1'b0;
        ext_inst_to_decode = '0;
        model_regs = '{default: '0};
        apply_reset();
        check_decode_fields();
        imm_ops_program();
        reg_ops_program();
        lui_and_x0_program();
        non_alu_program();
        ebreak_program();
        $display("tests %0d, checks %0d, writes %0d, errors %0d",
                 tests, checks, writes_seen, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* rv_core.f */
hw/rv_pkg.sv
hw/decode_if.sv
hw/block_ram.sv
hw/register_file.sv
hw/inst_decoder.sv
hw/int_alu.sv
hw/core_sequencer.sv
hw/rv_core.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= rv_core_tb
FILELIST ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "sim passed" $(LOG) && echo "result: PASS" || (echo "result: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
